/* design/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  lc3b_ctrl_pkg::lc3b_alu_sel sel,
    input  lc3b_ctrl_pkg::lc3b_alu_op  op,
    input  lc3b_isa_pkg::lc3b_word     ir,
    input  lc3b_isa_pkg::lc3b_word     a,
    input  lc3b_isa_pkg::lc3b_word     b,
    output lc3b_isa_pkg::lc3b_word     f
);

import lc3b_isa_pkg::*;
import lc3b_ctrl_pkg::*;

lc3b_word   opnd;  // selected second operand
logic [3:0] shamt; // shifts use low four bits

always_comb begin
    case (sel)
        alu_sel_imm4: opnd = {12'h000, ir[3:0]};
        alu_sel_imm5: opnd = {{11{ir[4]}}, ir[4:0]};
        alu_sel_off6: opnd = {{9{ir[5]}}, ir[5:0], 1'b0}; // word offset
        default:      opnd = b;                           // sr2 value
    endcase
end

assign shamt = opnd[3:0];

always_comb begin
    case (op)
        alu_add: f = a + opnd;
        alu_and: f = a & opnd;
        alu_not: f = ~a;
        alu_sll: f = a << shamt;
        alu_srl: f = a >> shamt;
        alu_sra: f = lc3b_word'($signed(a) >>> shamt); // sign fill
        default: f = a;                                // pass
    endcase
end

endmodule

`default_nettype wire

/* design/control_rom.sv */
`timescale 1ns/1ps
`default_nettype none

module control_rom (
    input  lc3b_isa_pkg::lc3b_word          ir_in,
    output lc3b_ctrl_pkg::lc3b_control_word control_out
);

import lc3b_isa_pkg::*;
import lc3b_ctrl_pkg::*;

lc3b_opcode opcode;
logic       imm_form;  // add/and bit 5
logic       shf_right; // shf bit 4
logic       shf_arith; // shf bit 5

assign opcode    = lc3b_opcode'(ir_in[OPC_LSB +: 4]);
assign imm_form  = ir_in[IMM_FLAG_BIT];
assign shf_right = ir_in[SHF_DIR_BIT];
assign shf_arith = ir_in[SHF_ARITH_BIT];

always_comb begin
    // quiet defaults, every case overrides what it needs
    control_out.branch                   = 1'b0;
    control_out.regfile_sr2_mux_sel      = 1'b0;       // sr2 field
    control_out.general_alu_mux_sel      = alu_sel_sr2;
    control_out.general_alu_op           = alu_pass;
    control_out.cc_load                  = 1'b0;
    control_out.cc_gen_mux_sel           = cc_sel_none;
    control_out.data_memory_write_enable = 1'b0;
    control_out.regfile_data_mux_sel     = wb_sel_none;
    control_out.regfile_load             = 1'b0;

    case (opcode)
        op_add, op_and: begin
            if (imm_form) begin
                control_out.general_alu_mux_sel = alu_sel_imm5; // sext imm5
            end else begin
                control_out.general_alu_mux_sel = alu_sel_sr2;  // register form
            end
            if (opcode == op_add) begin
                control_out.general_alu_op = alu_add;
            end else begin
                control_out.general_alu_op = alu_and;
            end
            control_out.cc_load              = 1'b1;       // nzp from result
            control_out.cc_gen_mux_sel       = cc_sel_alu;
            control_out.regfile_data_mux_sel = wb_sel_alu;
            control_out.regfile_load         = 1'b1;
        end

        op_not: begin
            control_out.general_alu_op       = alu_not;    // sr1 only
            control_out.cc_load              = 1'b1;
            control_out.cc_gen_mux_sel       = cc_sel_alu;
            control_out.regfile_data_mux_sel = wb_sel_alu;
            control_out.regfile_load         = 1'b1;
        end

        op_shf: begin
            control_out.general_alu_mux_sel = alu_sel_imm4; // amount in [3:0]
            if (!shf_right) begin
                control_out.general_alu_op = alu_sll;
            end else if (shf_arith) begin
                control_out.general_alu_op = alu_sra;       // sign fill
            end else begin
                control_out.general_alu_op = alu_srl;       // zero fill
            end
            control_out.cc_load              = 1'b1;
            control_out.cc_gen_mux_sel       = cc_sel_alu;
            control_out.regfile_data_mux_sel = wb_sel_alu;
            control_out.regfile_load         = 1'b1;
        end

        op_ldr: begin
            control_out.general_alu_mux_sel  = alu_sel_off6; // base + off6*2
            control_out.general_alu_op       = alu_add;
            control_out.cc_load              = 1'b1;         // nzp from loaded word
            control_out.cc_gen_mux_sel       = cc_sel_mdr;
            control_out.regfile_data_mux_sel = wb_sel_mdr;
            control_out.regfile_load         = 1'b1;
        end

        op_str: begin
            control_out.regfile_sr2_mux_sel      = 1'b1;         // store data via port b
            control_out.general_alu_mux_sel      = alu_sel_off6;
            control_out.general_alu_op           = alu_add;      // address
            control_out.data_memory_write_enable = 1'b1;
        end

        op_br: begin
            control_out.branch = 1'b1; // target computed in mem
        end

        default: begin
            control_out = '0; // unsupported, retires as nop
        end
    endcase
end

endmodule

`default_nettype wire

/* design/hazard_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module hazard_unit (
    input  lc3b_isa_pkg::lc3b_reg id_src_a,
    input  lc3b_isa_pkg::lc3b_reg id_src_b,
    input  logic                  id_uses_a,
    input  logic                  id_uses_b,
    input  logic                  ex_valid,
    input  logic                  ex_load,
    input  logic                  mem_valid,
    input  logic                  mem_load,
    input  lc3b_isa_pkg::lc3b_reg ex_dest,
    input  lc3b_isa_pkg::lc3b_reg mem_dest,
    input  logic                  branch_taken,
    input  logic                  wb_valid,
    input  logic                  credit_zero,
    output logic                  stall,
    output logic                  flush,
    output logic                  freeze
);

logic ex_writes;  // execute will write a register
logic mem_writes; // memory will write a register
logic raw_a;
logic raw_b;

assign ex_writes  = ex_valid && ex_load;
assign mem_writes = mem_valid && mem_load;

// writeback is covered by the regfile write-through
assign raw_a = id_uses_a && ((ex_writes && ex_dest == id_src_a) ||
                             (mem_writes && mem_dest == id_src_a));
assign raw_b = id_uses_b && ((ex_writes && ex_dest == id_src_b) ||
                             (mem_writes && mem_dest == id_src_b));

assign freeze = wb_valid && credit_zero;                        // retire port full
assign flush  = !freeze && branch_taken;
assign stall  = !freeze && !branch_taken && (raw_a || raw_b);   // flush kills decode anyway

endmodule

`default_nettype wire

/* design/lc3b_core.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_core (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic                   prog_we,
    input  logic [7:0]             prog_addr,
    input  lc3b_isa_pkg::lc3b_word prog_data,
    input  logic                   retire_credit,
    output logic                   retire_valid,
    output lc3b_isa_pkg::lc3b_word retire_pc,
    output logic                   retire_reg_we,
    output lc3b_isa_pkg::lc3b_reg  retire_reg,
    output lc3b_isa_pkg::lc3b_word retire_data,
    output logic [2:0]             retire_cc,
    output logic                   retire_mem_we,
    output lc3b_isa_pkg::lc3b_word retire_mem_addr,
    output lc3b_isa_pkg::lc3b_word retire_mem_data
);

import lc3b_isa_pkg::*;
import lc3b_ctrl_pkg::*;

lc3b_word imem [IMEM_WORDS];
lc3b_word dmem [DMEM_WORDS];

lc3b_word              pc, fetch_ir, br_target;
logic [2:0]            cc, cc_next;     // nzp
logic [CREDIT_W-1:0]   credits;
logic                  stall, flush, freeze, credit_zero;

// decode stage
logic                  id_valid, id_uses_a, id_uses_b;
lc3b_word              id_pc, id_ir, id_a, id_b;
lc3b_control_word      id_ctrl;
lc3b_reg               id_src_a, id_src_b;

// execute stage
logic                  ex_valid;
lc3b_word              ex_pc, ex_ir, ex_a, ex_b, ex_f;
lc3b_control_word      ex_ctrl;

// memory stage
logic                  mem_valid, branch_taken;
lc3b_word              mem_pc, mem_ir, mem_alu_out, mem_sdata, mem_rdata, cc_src;
lc3b_control_word      mem_ctrl;

// writeback stage
logic                  wb_valid;
lc3b_word              wb_pc, wb_ir, wb_alu_out, wb_mdr, wb_sdata, wb_data;
lc3b_control_word      wb_ctrl;

always_ff @(posedge clk) begin
    if (prog_we) begin
        imem[prog_addr] <= prog_data; // loaded while start is low
    end
end

assign fetch_ir = imem[pc[MEM_AW:1]]; // async fetch

always_ff @(posedge clk) begin
    if (rst) begin
        pc <= '0;
    end else if (!freeze) begin
        if (flush) begin
            pc <= br_target;
        end else if (start && !stall) begin
            pc <= pc + 16'd2;
        end
    end
end

control_rom u_rom (.ir_in(id_ir), .control_out(id_ctrl));

assign id_src_a  = id_ir[SR1_LSB +: 3];
assign id_src_b  = id_ctrl.regfile_sr2_mux_sel ? id_ir[DR_LSB +: 3] : id_ir[SR2_LSB +: 3];
assign id_uses_a = id_valid && (id_ctrl.regfile_load || id_ctrl.data_memory_write_enable);
assign id_uses_b = id_valid && (id_ctrl.regfile_sr2_mux_sel ||
                   (id_ctrl.regfile_load && id_ctrl.general_alu_mux_sel == alu_sel_sr2 &&
                    (id_ctrl.general_alu_op == alu_add || id_ctrl.general_alu_op == alu_and)));

regfile u_rf (
    .clk   (clk),
    .rst   (rst),
    .load  (wb_valid && wb_ctrl.regfile_load && !freeze),
    .dest  (wb_ir[DR_LSB +: 3]),
    .in    (wb_data),
    .src_a (id_src_a),
    .src_b (id_src_b),
    .reg_a (id_a),
    .reg_b (id_b)
);

alu u_alu (
    .sel (ex_ctrl.general_alu_mux_sel),
    .op  (ex_ctrl.general_alu_op),
    .ir  (ex_ir),
    .a   (ex_a),
    .b   (ex_b),
    .f   (ex_f)
);

hazard_unit u_hz (
    .id_src_a     (id_src_a),
    .id_src_b     (id_src_b),
    .id_uses_a    (id_uses_a),
    .id_uses_b    (id_uses_b),
    .ex_valid     (ex_valid),
    .ex_load      (ex_ctrl.regfile_load),
    .mem_valid    (mem_valid),
    .mem_load     (mem_ctrl.regfile_load),
    .ex_dest      (ex_ir[DR_LSB +: 3]),
    .mem_dest     (mem_ir[DR_LSB +: 3]),
    .branch_taken (branch_taken),
    .wb_valid     (wb_valid),
    .credit_zero  (credit_zero),
    .stall        (stall),
    .flush        (flush),
    .freeze       (freeze)
);

// memory stage: load data, cc source, branch resolution
assign mem_rdata    = dmem[mem_alu_out[MEM_AW:1]];
assign cc_src       = (mem_ctrl.cc_gen_mux_sel == cc_sel_mdr) ? mem_rdata : mem_alu_out;
assign cc_next      = cc_src[15] ? 3'b100 : (cc_src == '0) ? 3'b010 : 3'b001;
assign branch_taken = mem_valid && mem_ctrl.branch && |(mem_ir[DR_LSB +: 3] & cc);
assign br_target    = mem_pc + 16'd2 + {{6{mem_ir[8]}}, mem_ir[8:0], 1'b0};

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] <= '0;
        end
    end else if (mem_valid && mem_ctrl.data_memory_write_enable && !freeze) begin
        dmem[mem_alu_out[MEM_AW:1]] <= mem_sdata; // store at end of mem
    end
end

always_ff @(posedge clk) begin
    if (rst) begin
        cc <= 3'b010; // z
    end else if (mem_valid && mem_ctrl.cc_load && !freeze) begin
        cc <= cc_next;
    end
end

// stage valid bits
always_ff @(posedge clk) begin
    if (rst) begin
        id_valid  <= 1'b0;
        ex_valid  <= 1'b0;
        mem_valid <= 1'b0;
        wb_valid  <= 1'b0;
    end else if (!freeze) begin
        id_valid  <= flush ? 1'b0 : (stall ? id_valid : start);
        ex_valid  <= id_valid && !stall && !flush; // bubble on stall
        mem_valid <= ex_valid && !flush;
        wb_valid  <= mem_valid;                    // branch itself retires
    end
end

// stage payloads
always_ff @(posedge clk) begin
    if (!freeze) begin
        if (!stall) begin
            id_pc <= pc;
            id_ir <= fetch_ir;
        end
        ex_pc       <= id_pc;
        ex_ir       <= id_ir;
        ex_ctrl     <= id_ctrl; // control word travels from here on
        ex_a        <= id_a;
        ex_b        <= id_b;
        mem_pc      <= ex_pc;
        mem_ir      <= ex_ir;
        mem_ctrl    <= ex_ctrl;
        mem_alu_out <= ex_f;
        mem_sdata   <= ex_b;
        wb_pc       <= mem_pc;
        wb_ir       <= mem_ir;
        wb_ctrl     <= mem_ctrl;
        wb_alu_out  <= mem_alu_out;
        wb_mdr      <= mem_rdata;
        wb_sdata    <= mem_sdata;
    end
end

always_comb begin
    case (wb_ctrl.regfile_data_mux_sel)
        wb_sel_alu: wb_data = wb_alu_out;
        wb_sel_mdr: wb_data = wb_mdr;
        default:    wb_data = '0;
    endcase
end

// retire credits, one spent per record
always_ff @(posedge clk) begin
    if (rst) begin
        credits <= CREDIT_W'(RETIRE_CREDITS);
    end else begin
        credits <= credits - CREDIT_W'(retire_valid) + CREDIT_W'(retire_credit);
    end
end

assign credit_zero     = (credits == '0);
assign retire_valid    = wb_valid && !freeze;
assign retire_pc       = wb_pc;
assign retire_reg_we   = wb_valid && wb_ctrl.regfile_load;
assign retire_reg      = wb_ir[DR_LSB +: 3];
assign retire_data     = wb_data;
assign retire_cc       = cc; // already includes this instruction
assign retire_mem_we   = wb_valid && wb_ctrl.data_memory_write_enable;
assign retire_mem_addr = wb_alu_out;
assign retire_mem_data = wb_sdata;

endmodule

`default_nettype wire

/* design/lc3b_ctrl_pkg.sv */
`default_nettype none

package lc3b_ctrl_pkg;

typedef enum logic [2:0] {
    alu_add, alu_and, alu_not, alu_pass, alu_sll, alu_srl, alu_sra
} lc3b_alu_op;

// second alu operand
typedef enum logic [2:0] {
    alu_sel_sr2  = 3'b000,
    alu_sel_imm4 = 3'b001, // shift amount
    alu_sel_imm5 = 3'b010,
    alu_sel_off6 = 3'b100  // offset6 << 1
} lc3b_alu_sel;

typedef enum logic [1:0] {
    cc_sel_none = 2'b00,
    cc_sel_alu  = 2'b01,
    cc_sel_mdr  = 2'b10
} lc3b_cc_sel;

typedef enum logic [2:0] {
    wb_sel_none = 3'b000,
    wb_sel_mdr  = 3'b010,
    wb_sel_alu  = 3'b101
} lc3b_wb_sel;

typedef struct packed {
    logic        branch;                   // br, resolved in mem
    logic        regfile_sr2_mux_sel;      // 1 = read dest field as sr2
    lc3b_alu_sel general_alu_mux_sel;
    lc3b_alu_op  general_alu_op;
    logic        cc_load;
    lc3b_cc_sel  cc_gen_mux_sel;
    logic        data_memory_write_enable; // word store
    lc3b_wb_sel  regfile_data_mux_sel;
    logic        regfile_load;
} lc3b_control_word;

localparam int RETIRE_CREDITS = 4; // consumer buffer depth
localparam int CREDIT_W       = $clog2(RETIRE_CREDITS + 1);

endpackage

`default_nettype wire

/* design/lc3b_isa_pkg.sv */
`default_nettype none

package lc3b_isa_pkg;

typedef logic [15:0] lc3b_word; // data and instruction word
typedef logic [2:0]  lc3b_reg;  // register index

typedef enum logic [3:0] {
    op_br   = 4'b0000, // conditional branch
    op_add  = 4'b0001,
    op_ldb  = 4'b0010, // byte load, not supported
    op_stb  = 4'b0011, // byte store, not supported
    op_jsr  = 4'b0100,
    op_and  = 4'b0101,
    op_ldr  = 4'b0110, // word load
    op_str  = 4'b0111, // word store
    op_rti  = 4'b1000,
    op_not  = 4'b1001,
    op_ldi  = 4'b1010,
    op_sti  = 4'b1011,
    op_jmp  = 4'b1100,
    op_shf  = 4'b1101, // sll / srl / sra
    op_lea  = 4'b1110,
    op_trap = 4'b1111
} lc3b_opcode;

// instruction field positions
localparam int OPC_LSB       = 12; // opcode [15:12]
localparam int DR_LSB        = 9;  // dest / nzp [11:9]
localparam int SR1_LSB       = 6;  // base or sr1 [8:6]
localparam int SR2_LSB       = 0;  // sr2 [2:0]
localparam int IMM_FLAG_BIT  = 5;  // add/and immediate form
localparam int SHF_DIR_BIT   = 4;  // 1 = right shift
localparam int SHF_ARITH_BIT = 5;  // 1 = sign fill

// memories are word addressed with addr[8:1], wrapping
localparam int IMEM_WORDS = 256;
localparam int DMEM_WORDS = 256;
localparam int MEM_AW     = 8; // word index width

endpackage

`default_nettype wire

/* design/regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load,
    input  lc3b_isa_pkg::lc3b_reg  dest,
    input  lc3b_isa_pkg::lc3b_word in,
    input  lc3b_isa_pkg::lc3b_reg  src_a,
    input  lc3b_isa_pkg::lc3b_reg  src_b,
    output lc3b_isa_pkg::lc3b_word reg_a,
    output lc3b_isa_pkg::lc3b_word reg_b
);

import lc3b_isa_pkg::*;

lc3b_word regs [8]; // r0..r7

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
        end
    end else if (load) begin
        regs[dest] <= in; // from writeback
    end
end

// write-through so decode sees the retiring result
assign reg_a = (load && dest == src_a) ? in : regs[src_a];
assign reg_b = (load && dest == src_b) ? in : regs[src_b];

endmodule

`default_nettype wire

/* list.f */
design/lc3b_isa_pkg.sv
design/lc3b_ctrl_pkg.sv
design/control_rom.sv
design/regfile.sv
design/alu.sv
design/hazard_unit.sv
design/lc3b_core.sv
verification/clock_gen.sv
verification/tb_lc3b_core.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the lc3b_core testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --top-module tb_lc3b_core -f list.f --Mdir obj_dir -o tb_lc3b_core

./obj_dir/tb_lc3b_core > sim.log 2>&1
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"

/* verification/clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_gen (
    input  logic reset_req, // starts a fresh reset pulse
    output logic clk,
    output logic rst
);

logic [2:0] rst_cnt = 3'd4; // reset cycles still to go

initial begin
    clk = 1'b0;
end

always #5 clk = ~clk; // 10 ns period

always @(posedge clk) begin
    if (reset_req) begin
        rst_cnt <= 3'd4;
    end else if (rst_cnt != 3'd0) begin
        rst_cnt <= rst_cnt - 3'd1;
    end
end

assign rst = (rst_cnt != 3'd0); // high for four rising edges

endmodule

`default_nettype wire

/* verification/tb_lc3b_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lc3b_core;

import lc3b_isa_pkg::*;
import lc3b_ctrl_pkg::*;

logic       clk;
logic       rst;
logic       reset_req;
logic       start;
logic       prog_we;
logic [7:0] prog_addr;
lc3b_word   prog_data;
logic       retire_credit;
logic       retire_valid;
lc3b_word   retire_pc;
logic       retire_reg_we;
lc3b_reg    retire_reg;
lc3b_word   retire_data;
logic [2:0] retire_cc;
logic       retire_mem_we;
lc3b_word   retire_mem_addr;
lc3b_word   retire_mem_data;

integer     seed = 32'h6176dac3;
lc3b_word   prog [IMEM_WORDS]; // image for the next test
lc3b_word   rm [8];            // model registers
lc3b_word   mm [DMEM_WORDS];   // model data memory
logic [2:0] ccm;               // model nzp

// expected retire stream by record
lc3b_word   exp_pc [IMEM_WORDS];
lc3b_word   exp_data [IMEM_WORDS];
lc3b_word   exp_maddr [IMEM_WORDS];
lc3b_word   exp_mdata [IMEM_WORDS];
lc3b_reg    exp_reg [IMEM_WORDS];
logic [2:0] exp_cc [IMEM_WORDS];
logic       exp_we [IMEM_WORDS];
logic       exp_mwe [IMEM_WORDS];

string test_name;
int    n_exp;
int    rec_idx;     // next record to compare
int    received;    // records seen this test
int    returned;    // credits handed back
int    credit_wait; // idle cycles before the next credit
int    test_errors;
int    total_errors;
int    tests_run;
int    cycle_limit; // abort point of the running test
int    run_cycles;  // cycles spent in the running test
bit    active;
bit    slow_credit; // long consumer gaps

clock_gen u_clk (.reset_req(reset_req), .clk(clk), .rst(rst));

lc3b_core DUT (
    .clk             (clk),
    .rst             (rst),
    .start           (start),
    .prog_we         (prog_we),
    .prog_addr       (prog_addr),
    .prog_data       (prog_data),
    .retire_credit   (retire_credit),
    .retire_valid    (retire_valid),
    .retire_pc       (retire_pc),
    .retire_reg_we   (retire_reg_we),
    .retire_reg      (retire_reg),
    .retire_data     (retire_data),
    .retire_cc       (retire_cc),
    .retire_mem_we   (retire_mem_we),
    .retire_mem_addr (retire_mem_addr),
    .retire_mem_data (retire_mem_data)
);

function automatic int rnd(input int n);
    return $unsigned($random(seed)) % n; // 0 .. n-1
endfunction

function automatic lc3b_word alu_instr(input lc3b_reg dr, input lc3b_reg sr1, input lc3b_reg sr2);
    lc3b_word w;
    case (rnd(6))
        0:       w = {op_add, dr, sr1, 3'b000, sr2};
        1:       w = {op_add, dr, sr1, 1'b1, 5'(rnd(32))};
        2:       w = {op_and, dr, sr1, 3'b000, sr2};
        3:       w = {op_and, dr, sr1, 1'b1, 5'(rnd(32))};
        4:       w = {op_not, dr, sr1, 6'b111111};
        default: w = {op_shf, dr, sr1, 2'(rnd(4)), 4'(rnd(16))}; // sll, srl or sra
    endcase
    return w;
endfunction

function automatic lc3b_opcode unsupported_opcode();
    lc3b_opcode o;
    o = lc3b_opcode'(4'(rnd(16)));
    while (o inside {op_br, op_add, op_and, op_not, op_shf, op_ldr, op_str}) begin
        o = lc3b_opcode'(4'(rnd(16)));
    end
    return o;
endfunction

task automatic seed_registers(); // add-immediate into r0..r7
    int i;
    for (i = 0; i < 8; i++) begin
        prog[i] = {op_add, 3'(i), 3'(i), 1'b1, 5'(rnd(32))};
    end
endtask

task automatic make_alu_mix();
    int i;
    seed_registers();
    for (i = 8; i < IMEM_WORDS; i++) begin
        prog[i] = alu_instr(3'(rnd(8)), 3'(rnd(8)), 3'(rnd(8)));
    end
endtask

task automatic chain_dependent_ops();
    int      i;
    lc3b_reg last;
    seed_registers();
    last = 3'd0;
    for (i = 8; i < IMEM_WORDS; i++) begin
        prog[i] = alu_instr(3'(rnd(3)), last, 3'(rnd(3))); // three regs give dense raw
        last    = prog[i][11:9];
    end
endtask

task automatic interleave_loads_stores();
    int i;
    seed_registers();
    for (i = 8; i < IMEM_WORDS; i++) begin
        case (rnd(3))
            0:       prog[i] = {op_str, 3'(4 + rnd(4)), 3'(1 + rnd(3)), 6'(rnd(8))};
            1:       prog[i] = {op_ldr, 3'(4 + rnd(4)), 3'(1 + rnd(3)), 6'(rnd(8))};
            default: prog[i] = {op_add, 3'(4 + rnd(4)), 3'(4 + rnd(4)), 1'b1, 5'(rnd(32))};
        endcase
    end
endtask

task automatic scatter_branches();
    int i;
    seed_registers();
    for (i = 8; i < IMEM_WORDS; i++) begin
        if (rnd(3) == 0) begin
            prog[i] = {op_br, 3'(rnd(8)), 9'(rnd(32) - 16)}; // short hops both ways
        end else begin
            prog[i] = alu_instr(3'(rnd(8)), 3'(rnd(8)), 3'(rnd(8)));
        end
    end
endtask

task automatic mix_unknown_opcodes();
    int i;
    seed_registers();
    for (i = 8; i < IMEM_WORDS; i++) begin
        if (rnd(3) == 0) begin
            prog[i] = {unsupported_opcode(), 12'(rnd(4096))};
        end else begin
            prog[i] = alu_instr(3'(rnd(8)), 3'(rnd(8)), 3'(rnd(8)));
        end
    end
endtask

// sequential lc-3b model builds the expected retire stream
task automatic run_model(input int n);
    lc3b_word   pc_m;
    lc3b_word   next_pc;
    lc3b_word   ir;
    lc3b_word   val;
    lc3b_word   addr;
    lc3b_opcode opc;
    lc3b_reg    dr;
    lc3b_reg    sr1;
    lc3b_reg    sr2;
    logic [3:0] amt;
    logic       wr;
    int         k;
    for (k = 0; k < 8; k++) begin
        rm[k] = '0;
    end
    for (k = 0; k < DMEM_WORDS; k++) begin
        mm[k] = '0;
    end
    ccm  = 3'b010; // z out of reset
    pc_m = '0;
    for (k = 0; k < n; k++) begin
        ir      = prog[pc_m[8:1]];
        opc     = lc3b_opcode'(ir[15:12]);
        dr      = ir[11:9];
        sr1     = ir[8:6];
        sr2     = ir[2:0];
        amt     = ir[3:0];
        addr    = rm[sr1] + {{9{ir[5]}}, ir[5:0], 1'b0}; // base + offset6 words
        next_pc = pc_m + 16'd2;
        wr      = 1'b0;
        val     = '0;
        exp_pc[k]    = pc_m;
        exp_mwe[k]   = 1'b0;
        exp_maddr[k] = addr;
        exp_mdata[k] = rm[dr]; // store data
        case (opc)
            op_add: begin
                val = rm[sr1] + (ir[5] ? {{11{ir[4]}}, ir[4:0]} : rm[sr2]);
                wr  = 1'b1;
            end
            op_and: begin
                val = rm[sr1] & (ir[5] ? {{11{ir[4]}}, ir[4:0]} : rm[sr2]);
                wr  = 1'b1;
            end
            op_not: begin
                val = ~rm[sr1];
                wr  = 1'b1;
            end
            op_shf: begin
                val = rm[sr1] >> amt;
                if (!ir[4]) begin
                    val = rm[sr1] << amt;
                end else if (ir[5] && rm[sr1][15]) begin
                    val = val | ~(16'hffff >> amt); // copies of the sign bit
                end
                wr = 1'b1;
            end
            op_ldr: begin
                val = mm[addr[8:1]];
                wr  = 1'b1;
            end
            op_str: begin
                mm[addr[8:1]] = rm[dr];
                exp_mwe[k]    = 1'b1;
            end
            op_br: begin
                if ((dr & ccm) != 3'b000) begin
                    next_pc = pc_m + 16'd2 + {{6{ir[8]}}, ir[8:0], 1'b0};
                end
            end
            default: begin
            end
        endcase
        if (wr) begin
            rm[dr] = val;
            ccm    = val[15] ? 3'b100 : ((val == '0) ? 3'b010 : 3'b001);
        end
        exp_we[k]   = wr;
        exp_reg[k]  = dr;
        exp_data[k] = val;
        exp_cc[k]   = ccm;
        pc_m        = next_pc;
    end
endtask

task automatic report_mismatch(input string field, input lc3b_word expv, input lc3b_word actv);
    $display("FAIL %s record %0d %s expected %h actual %h",
             test_name, rec_idx, field, expv, actv);
    test_errors++;
endtask

task automatic compare_record();
    if (retire_pc !== exp_pc[rec_idx]) begin
        report_mismatch("retire_pc", exp_pc[rec_idx], retire_pc);
    end
    if (retire_reg_we !== exp_we[rec_idx]) begin
        report_mismatch("retire_reg_we", 16'(exp_we[rec_idx]), 16'(retire_reg_we));
    end
    if (retire_mem_we !== exp_mwe[rec_idx]) begin
        report_mismatch("retire_mem_we", 16'(exp_mwe[rec_idx]), 16'(retire_mem_we));
    end
    if (retire_cc !== exp_cc[rec_idx]) begin
        report_mismatch("retire_cc", 16'(exp_cc[rec_idx]), 16'(retire_cc));
    end
    if (exp_we[rec_idx] && retire_reg !== exp_reg[rec_idx]) begin
        report_mismatch("retire_reg", 16'(exp_reg[rec_idx]), 16'(retire_reg));
    end
    if (exp_we[rec_idx] && retire_data !== exp_data[rec_idx]) begin
        report_mismatch("retire_data", exp_data[rec_idx], retire_data);
    end
    if (exp_mwe[rec_idx] && retire_mem_addr !== exp_maddr[rec_idx]) begin
        report_mismatch("retire_mem_addr", exp_maddr[rec_idx], retire_mem_addr);
    end
    if (exp_mwe[rec_idx] && retire_mem_data !== exp_mdata[rec_idx]) begin
        report_mismatch("retire_mem_data", exp_mdata[rec_idx], retire_mem_data);
    end
endtask

// retire monitor and credit consumer on the falling edge
always @(negedge clk) begin
    if (active) begin
        if (retire_valid) begin
            if (received - returned >= RETIRE_CREDITS) begin
                $display("%s: a record retired while all %0d credits were in use",
                         test_name, RETIRE_CREDITS);
                test_errors++;
            end
            if (rec_idx < n_exp) begin
                compare_record();
                rec_idx++;
            end
        end
        if (credit_wait > 0) begin
            retire_credit = 1'b0;
            credit_wait--;
        end else if (received > returned) begin
            retire_credit = 1'b1; // only for records already taken
            returned++;
            credit_wait = slow_credit ? rnd(31) : rnd(7);
        end else begin
            retire_credit = 1'b0;
        end
        if (retire_valid) begin
            received++;
        end
    end
end

// cycle watchdog for the running test
initial begin
    while (!active || run_cycles < cycle_limit) begin
        @(negedge clk);
        if (active) begin
            run_cycles++;
        end
    end
    $display("%s: timeout, only %0d of %0d records after %0d cycles",
             test_name, rec_idx, n_exp, run_cycles);
    $display("Test failed");
    $finish;
end

task automatic reset_dut();
    @(negedge clk);
    start     = 1'b0;
    reset_req = 1'b1;
    @(negedge clk);
    reset_req = 1'b0;
    while (rst) begin
        @(negedge clk);
    end
endtask

task automatic load_program();
    int i;
    for (i = 0; i < IMEM_WORDS; i++) begin
        @(negedge clk);
        prog_we   = 1'b1;
        prog_addr = i[7:0];
        prog_data = prog[i];
    end
    @(negedge clk);
    prog_we = 1'b0;
endtask

task automatic run_test(input string name, input int n, input bit long_gaps);
    active        = 1'b0;
    retire_credit = 1'b0;
    reset_dut();
    load_program();
    run_model(n);
    test_name   = name;
    n_exp       = n;
    rec_idx     = 0;
    received    = 0;
    returned    = 0;
    credit_wait = 0;
    test_errors = 0;
    slow_credit = long_gaps;
    cycle_limit = 40 * n + 200;
    run_cycles  = 0;
    @(negedge clk);
    active = 1'b1;
    start  = 1'b1;
    while (rec_idx < n_exp) begin
        @(negedge clk);
    end
    active        = 1'b0;
    start         = 1'b0;
    retire_credit = 1'b0;
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
        $display("%s: ok, %0d records", name, n);
    end else begin
        $display("%s: %0d errors in %0d records", name, test_errors, n);
    end
endtask

initial begin
    reset_req     = 1'b0;
    start         = 1'b0;
    prog_we       = 1'b0;
    prog_addr     = '0;
    prog_data     = '0;
    retire_credit = 1'b0;
    active        = 1'b0;
    slow_credit   = 1'b0;
    n_exp         = 0;
    rec_idx       = 0;
    total_errors  = 0;
    tests_run     = 0;
    cycle_limit   = 0;
    run_cycles    = 0;
    make_alu_mix();
    run_test("alu_ops", 208, 1'b0);
    chain_dependent_ops();
    run_test("raw_chains", 200, 1'b0);
    interleave_loads_stores();
    run_test("load_store", 200, 1'b0);
    scatter_branches();
    run_test("branches", 200, 1'b0);
    chain_dependent_ops();
    run_test("credit_backpressure", 150, 1'b1);
    mix_unknown_opcodes();
    run_test("unknown_opcode", 200, 1'b0);
    $display("tests run %0d, total errors %0d", tests_run, total_errors);
    if (total_errors == 0) begin
        $display("Test passed");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule

`default_nettype wire
